// File: rtl/fp_fmt_pkg.sv
// single-precision float format
// field widths, bias and result word layout

package fp_fmt_pkg;

    // ----------------------------------------------------------------------
    // format constants
    // ----------------------------------------------------------------------

    // exponent bias for binary32
    localparam int exp_bias = 127;

    localparam int exp_w  = 8;
    localparam int frac_w = 23;

    // ----------------------------------------------------------------------
    // result word
    // ----------------------------------------------------------------------

    // field view, msb first as in the IEEE-754 layout
    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exponent;
        logic [frac_w-1:0] fraction;
    } fp32_fields_t;

    // same 32 bits seen either as fields or as a raw word
    typedef union packed {
        logic [exp_w+frac_w:0] raw;
        fp32_fields_t          fields;
    } fp32_word_t;

endpackage

// File: rtl/cvt_ctrl_pkg.sv
// converter control and datapath constants

package cvt_ctrl_pkg;

    // ----------------------------------------------------------------------
    // datapath widths
    // ----------------------------------------------------------------------

    // integer operand width
    localparam int int_w = 32;

    // full leading-zero count, 0..31
    localparam int cnt_w = 5;

    // ----------------------------------------------------------------------
    // pipeline
    // ----------------------------------------------------------------------

    // register stages between operand and result
    localparam int pipe_depth = 3;

endpackage

// File: rtl/leading_zero.sv
// 16-bit leading-zero counter
// nibble terms merged pairwise

module leading_zero #(
    parameter int RANGE_WIDTH_LCZ = 16,
    parameter int D_SIZE_LZC      = 4
) (
    input  logic [RANGE_WIDTH_LCZ-1:0] in_range,
    output logic [D_SIZE_LZC-1:0]      lzc_out,
    output logic                       v
);

    // ----------------------------------------------------------------------
    // per-nibble terms
    // ----------------------------------------------------------------------

    logic [RANGE_WIDTH_LCZ/4-1:0] grp_v;
    logic [1:0]                   grp_cnt [RANGE_WIDTH_LCZ/4];

    // group 0 sits at the lsb end
    for (genvar g = 0; g < RANGE_WIDTH_LCZ / 4; g++) begin : g_nib
        wire [3:0] nib = in_range[4*g +: 4];

        assign grp_v[g] = |nib;
        // upper pair empty
        assign grp_cnt[g][1] = ~(nib[3] | nib[2]);
        // odd count inside the nibble, 3 when the nibble is empty
        assign grp_cnt[g][0] = ~(nib[3] | (~nib[2] & nib[1]));
    end

    // ----------------------------------------------------------------------
    // byte merge
    // ----------------------------------------------------------------------

    logic       v_hi;
    logic       v_lo;
    logic [2:0] cnt_hi;
    logic [2:0] cnt_lo;

    // upper byte, groups 3 and 2
    assign v_hi   = grp_v[3] | grp_v[2];
    assign cnt_hi = grp_v[3] ? {1'b0, grp_cnt[3]} : {1'b1, grp_cnt[2]};

    // lower byte, groups 1 and 0
    assign v_lo   = grp_v[1] | grp_v[0];
    assign cnt_lo = grp_v[1] ? {1'b0, grp_cnt[1]} : {1'b1, grp_cnt[0]};

    // ----------------------------------------------------------------------
    // final merge
    // ----------------------------------------------------------------------

    // all ones when the input is empty
    assign v       = v_hi | v_lo;
    assign lzc_out = v_hi ? {1'b0, cnt_hi} : {1'b1, cnt_lo};

endmodule

// File: rtl/magnitude_prep.sv
// stage 1, sign and magnitude

module magnitude_prep (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ld_s1,
    input  logic                          is_signed,
    input  logic [cvt_ctrl_pkg::int_w-1:0] operand,
    output logic                          sign_s1,
    output logic [cvt_ctrl_pkg::int_w-1:0] mag_s1
);

    logic                          sign_c;
    logic [cvt_ctrl_pkg::int_w-1:0] mag_c;

    // ----------------------------------------------------------------------
    // absolute value
    // ----------------------------------------------------------------------

    // top bit only counts as a sign in signed mode
    assign sign_c = is_signed & operand[cvt_ctrl_pkg::int_w-1];

    // two's complement negate; the most negative value maps to 2^31,
    // which is still representable as an unsigned magnitude
    assign mag_c = sign_c ? (~operand + 1'b1) : operand;

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------

    // no loads while held in reset
    always_ff @(posedge clk) begin
        if (rst_n && ld_s1) begin
            sign_s1 <= sign_c;
            mag_s1  <= mag_c;
        end
    end

endmodule

// File: rtl/normalize_shift.sv
// stage 2, leading-zero count and normalize

module normalize_shift (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ld_s2,
    input  logic                           sign_s1,
    input  logic [cvt_ctrl_pkg::int_w-1:0] mag_s1,
    output logic                           sign_s2,
    output logic                           zero_s2,
    output logic [cvt_ctrl_pkg::cnt_w-1:0] lz_s2,
    output logic [cvt_ctrl_pkg::int_w-1:0] norm_s2
);

    logic [cvt_ctrl_pkg::cnt_w-2:0] lzc_hi;
    logic [cvt_ctrl_pkg::cnt_w-2:0] lzc_lo;
    logic                           v_hi;
    logic                           v_lo;
    logic [cvt_ctrl_pkg::cnt_w-1:0] lz_c;
    logic                           zero_c;
    logic [cvt_ctrl_pkg::int_w-1:0] norm_c;

    // ----------------------------------------------------------------------
    // half-word counters
    // ----------------------------------------------------------------------

    leading_zero #(
        .RANGE_WIDTH_LCZ (cvt_ctrl_pkg::int_w / 2),
        .D_SIZE_LZC      (cvt_ctrl_pkg::cnt_w - 1)
    ) u_lz_hi (
        .in_range (mag_s1[cvt_ctrl_pkg::int_w-1:cvt_ctrl_pkg::int_w/2]),
        .lzc_out  (lzc_hi),
        .v        (v_hi)
    );

    leading_zero #(
        .RANGE_WIDTH_LCZ (cvt_ctrl_pkg::int_w / 2),
        .D_SIZE_LZC      (cvt_ctrl_pkg::cnt_w - 1)
    ) u_lz_lo (
        .in_range (mag_s1[cvt_ctrl_pkg::int_w/2-1:0]),
        .lzc_out  (lzc_lo),
        .v        (v_lo)
    );

    // ----------------------------------------------------------------------
    // full count and shift
    // ----------------------------------------------------------------------

    // low half only matters when the high half is empty, adds 16
    assign lz_c   = v_hi ? {1'b0, lzc_hi} : {1'b1, lzc_lo};
    assign zero_c = ~(v_hi | v_lo);

    // leading one ends up at bit 31
    assign norm_c = mag_s1 << lz_c;

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst_n && ld_s2) begin
            sign_s2 <= sign_s1;
            zero_s2 <= zero_c;
            lz_s2   <= lz_c;
            norm_s2 <= norm_c;
        end
    end

endmodule

// File: rtl/round_pack.sv
// stage 3, round to nearest even and pack

module round_pack (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ld_s3,
    input  logic                           sign_s2,
    input  logic                           zero_s2,
    input  logic [cvt_ctrl_pkg::cnt_w-1:0] lz_s2,
    input  logic [cvt_ctrl_pkg::int_w-1:0] norm_s2,
    output fp_fmt_pkg::fp32_word_t         result,
    output logic                           inexact
);

    logic [fp_fmt_pkg::frac_w-1:0] frac_raw;
    logic                          lsb;
    logic                          guard;
    logic                          sticky;
    logic                          round_up;
    logic [fp_fmt_pkg::frac_w:0]   frac_sum;
    logic                          carry;
    logic [31:0]                   exp_full;
    logic [fp_fmt_pkg::exp_w-1:0]  exp_c;

    // ----------------------------------------------------------------------
    // rounding
    // ----------------------------------------------------------------------

    // bit 31 is the hidden one and drops out
    assign frac_raw = norm_s2[cvt_ctrl_pkg::int_w-2 -: fp_fmt_pkg::frac_w];
    assign lsb      = norm_s2[cvt_ctrl_pkg::int_w-1-fp_fmt_pkg::frac_w];
    assign guard    = norm_s2[cvt_ctrl_pkg::int_w-2-fp_fmt_pkg::frac_w];
    assign sticky   = |norm_s2[cvt_ctrl_pkg::int_w-3-fp_fmt_pkg::frac_w:0];

    // ties go to the even fraction
    assign round_up = guard & (sticky | lsb);
    assign frac_sum = {1'b0, frac_raw} + round_up;

    // all-ones fraction rolls over into the exponent
    assign carry = frac_sum[fp_fmt_pkg::frac_w];

    // ----------------------------------------------------------------------
    // exponent
    // ----------------------------------------------------------------------

    // bias + 31 - lz, one more on carry; max 159 fits in 8 bits
    assign exp_full = fp_fmt_pkg::exp_bias + (cvt_ctrl_pkg::int_w - 1)
                      - 32'(lz_s2) + 32'(carry);
    assign exp_c    = exp_full[fp_fmt_pkg::exp_w-1:0];

    // ----------------------------------------------------------------------
    // pack and register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst_n && ld_s3) begin
            if (zero_s2) begin
                // +0
                result.fields.sign     <= 1'b0;
                result.fields.exponent <= '0;
                result.fields.fraction <= '0;
                inexact                <= 1'b0;
            end else begin
                result.fields.sign     <= sign_s2;
                result.fields.exponent <= exp_c;
                result.fields.fraction <= frac_sum[fp_fmt_pkg::frac_w-1:0];
                inexact                <= guard | sticky;
            end
        end
    end

endmodule

// File: rtl/cvt_ctrl.sv
// converter valid chain and stage enables

module cvt_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic ld_s1,
    output logic ld_s2,
    output logic ld_s3,
    output logic out_valid
);

    // bit k set means stage k+1 holds a live operand
    logic [cvt_ctrl_pkg::pipe_depth-1:0] valid_q;

    // ----------------------------------------------------------------------
    // valid chain
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[cvt_ctrl_pkg::pipe_depth-2:0], in_valid};
        end
    end

    // ----------------------------------------------------------------------
    // stage enables
    // ----------------------------------------------------------------------

    // stage 1 captures straight from the input
    assign ld_s1 = in_valid;

    // each later stage loads one cycle after the one before it
    assign ld_s2 = valid_q[0];
    assign ld_s3 = valid_q[cvt_ctrl_pkg::pipe_depth-2];

    // result register was loaded on the previous edge
    assign out_valid = valid_q[cvt_ctrl_pkg::pipe_depth-1];

endmodule

// File: rtl/int_to_float_top.sv
// integer to float32 converter, top level

module int_to_float_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic                           is_signed,
    input  logic [cvt_ctrl_pkg::int_w-1:0] operand,
    output logic                           out_valid,
    output logic [cvt_ctrl_pkg::int_w-1:0] result,
    output logic                           inexact
);

    logic                           ld_s1;
    logic                           ld_s2;
    logic                           ld_s3;
    logic                           sign_s1;
    logic [cvt_ctrl_pkg::int_w-1:0] mag_s1;
    logic                           sign_s2;
    logic                           zero_s2;
    logic [cvt_ctrl_pkg::cnt_w-1:0] lz_s2;
    logic [cvt_ctrl_pkg::int_w-1:0] norm_s2;
    fp_fmt_pkg::fp32_word_t         result_w;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------

    cvt_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ld_s1     (ld_s1),
        .ld_s2     (ld_s2),
        .ld_s3     (ld_s3),
        .out_valid (out_valid)
    );

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------

    magnitude_prep u_s1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_s1     (ld_s1),
        .is_signed (is_signed),
        .operand   (operand),
        .sign_s1   (sign_s1),
        .mag_s1    (mag_s1)
    );

    normalize_shift u_s2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ld_s2   (ld_s2),
        .sign_s1 (sign_s1),
        .mag_s1  (mag_s1),
        .sign_s2 (sign_s2),
        .zero_s2 (zero_s2),
        .lz_s2   (lz_s2),
        .norm_s2 (norm_s2)
    );

    round_pack u_s3 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ld_s3   (ld_s3),
        .sign_s2 (sign_s2),
        .zero_s2 (zero_s2),
        .lz_s2   (lz_s2),
        .norm_s2 (norm_s2),
        .result  (result_w),
        .inexact (inexact)
    );

    // raw view of the packed word
    assign result = result_w.raw;

endmodule

// File: tb/cvt_checker.sv
// converter result checker

module cvt_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic                           is_signed,
    input  logic [cvt_ctrl_pkg::int_w-1:0] operand,
    input  logic                           has_ref,
    input  logic [31:0]                    ref_word,
    input  logic                           ref_inexact,
    input  logic                           out_valid,
    input  logic [31:0]                    result,
    input  logic                           inexact,
    output int                             pass_cnt,
    output int                             fail_cnt,
    output int                             in_cnt,
    output int                             out_cnt,
    output int                             pending
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] operand;
        logic        is_signed;
        logic        has_ref;
        logic [31:0] ref_word;
        logic        ref_inexact;
        logic [31:0] cycle;
    } entry_t;

    entry_t      pend_q [$];
    logic [31:0] cycle;

    // ----------------------------------------------------------------------
    // reference model, returns {word, inexact}
    // ----------------------------------------------------------------------

    function automatic logic [32:0] convert_ref(input logic [31:0] op, input logic sgn);
        logic        neg;
        logic [63:0] mag;
        logic [63:0] kept;
        logic [63:0] rem;
        logic [63:0] half;
        logic [7:0]  e;
        logic        inx;
        int          p;
        int          sh;
        neg = sgn & op[31];
        mag = neg ? (64'h1_0000_0000 - 64'(op)) : 64'(op);
        if (mag == 64'h0) begin
            return 33'h0;
        end
        // position of the leading one
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        inx = 1'b0;
        if (p <= fp_fmt_pkg::frac_w) begin
            kept = mag << (fp_fmt_pkg::frac_w - p);
        end else begin
            sh   = p - fp_fmt_pkg::frac_w;
            kept = mag >> sh;
            rem  = mag & ((64'h1 << sh) - 64'h1);
            half = 64'h1 << (sh - 1);
            inx  = (rem != 64'h0);
            // above half, or exactly half with an odd kept value
            if (rem > half || (rem == half && kept[0])) begin
                kept = kept + 64'h1;
            end
        end
        e = 8'(fp_fmt_pkg::exp_bias + p);
        // significand overflowed to 2^24
        if (kept[24]) begin
            e    = e + 8'd1;
            kept = kept >> 1;
        end
        return {neg, e, kept[22:0], inx};
    endfunction

    // ----------------------------------------------------------------------
    // queue and compare
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        entry_t      ent;
        logic [32:0] model;
        logic [31:0] exp_word;
        logic        exp_inx;
        logic        ok;
        if (!rst_n) begin
            cycle    = 0;
            pass_cnt = 0;
            fail_cnt = 0;
            in_cnt   = 0;
            out_cnt  = 0;
            pend_q.delete();
        end else begin
            cycle = cycle + 1;
            if (out_valid) begin
                out_cnt = out_cnt + 1;
                if (pend_q.size() == 0) begin
                    $display("test %0d: result appeared with no operand outstanding", out_cnt);
                    fail_cnt = fail_cnt + 1;
                end else begin
                    ent      = pend_q.pop_front();
                    model    = convert_ref(ent.operand, ent.is_signed);
                    exp_word = ent.has_ref ? ent.ref_word : model[32:1];
                    exp_inx  = ent.has_ref ? ent.ref_inexact : model[0];
                    ok       = 1'b1;
                    if (result !== exp_word) begin
                        $display("[FAIL] test %0d result expected %h actual %h",
                                 out_cnt, exp_word, result);
                        ok = 1'b0;
                    end
                    if (inexact !== exp_inx) begin
                        $display("[FAIL] test %0d inexact expected %h actual %h",
                                 out_cnt, exp_inx, inexact);
                        ok = 1'b0;
                    end
                    if (cycle - ent.cycle != cvt_ctrl_pkg::pipe_depth) begin
                        $display("test %0d: result came %0d cycles after its operand, not %0d",
                                 out_cnt, cycle - ent.cycle, cvt_ctrl_pkg::pipe_depth);
                        ok = 1'b0;
                    end
                    if (ok) begin
                        pass_cnt = pass_cnt + 1;
                        $display("[PASS] test %0d operand %h gives %h", out_cnt,
                                 ent.operand, result);
                    end else begin
                        fail_cnt = fail_cnt + 1;
                    end
                end
            end
            if (in_valid) begin
                pend_q.push_back({operand, is_signed, has_ref, ref_word, ref_inexact, cycle});
                in_cnt = in_cnt + 1;
            end
        end
        pending = pend_q.size();
    end

endmodule

// File: tb/tb_int_to_float.sv
// integer to float converter testbench

module tb_int_to_float;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] operand;
        logic        is_signed;
        logic [31:0] word;
        logic        inexact;
    } row_t;

    localparam int n_dir       = 20;
    localparam int n_rand      = 200;
    localparam int drain_limit = 20;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic                           is_signed;
    logic [cvt_ctrl_pkg::int_w-1:0] operand;
    logic                           out_valid;
    logic [cvt_ctrl_pkg::int_w-1:0] result;
    logic                           inexact;
    logic                           has_ref;
    logic [31:0]                    ref_word;
    logic                           ref_inexact;
    int                             pass_cnt;
    int                             fail_cnt;
    int                             in_cnt;
    int                             out_cnt;
    int                             pending;
    int                             n_issued;

    // operand, signed, expected word, expected inexact
    row_t dir_rows [n_dir] = '{
        {32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
        {32'h0000_0000, 1'b1, 32'h0000_0000, 1'b0},
        {32'h0000_0001, 1'b0, 32'h3F80_0000, 1'b0},
        {32'h0000_0001, 1'b1, 32'h3F80_0000, 1'b0},
        {32'h0000_0002, 1'b0, 32'h4000_0000, 1'b0},
        {32'h0000_0010, 1'b1, 32'h4180_0000, 1'b0},
        {32'h0001_0000, 1'b0, 32'h4780_0000, 1'b0},
        {32'hFFFF_FFFF, 1'b1, 32'hBF80_0000, 1'b0},
        {32'hFFFF_FFFE, 1'b1, 32'hC000_0000, 1'b0},
        {32'h8000_0000, 1'b1, 32'hCF00_0000, 1'b0},
        {32'h8000_0000, 1'b0, 32'h4F00_0000, 1'b0},
        {32'hFFFF_FFFF, 1'b0, 32'h4F80_0000, 1'b1},
        {32'h0100_0001, 1'b0, 32'h4B80_0000, 1'b1},
        {32'h0100_0003, 1'b0, 32'h4B80_0002, 1'b1},
        {32'h0100_0002, 1'b0, 32'h4B80_0001, 1'b0},
        {32'h0100_0005, 1'b0, 32'h4B80_0002, 1'b1},
        {32'h0000_FFFF, 1'b0, 32'h477F_FF00, 1'b0},
        {32'h0000_0300, 1'b1, 32'h4440_0000, 1'b0},
        {32'hFFFF_0001, 1'b1, 32'hC77F_FF00, 1'b0},
        {32'h7FFF_FFFF, 1'b1, 32'h4F00_0000, 1'b1}
    };

    int_to_float_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .is_signed (is_signed),
        .operand   (operand),
        .out_valid (out_valid),
        .result    (result),
        .inexact   (inexact)
    );

    cvt_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .is_signed   (is_signed),
        .operand     (operand),
        .has_ref     (has_ref),
        .ref_word    (ref_word),
        .ref_inexact (ref_inexact),
        .out_valid   (out_valid),
        .result      (result),
        .inexact     (inexact),
        .pass_cnt    (pass_cnt),
        .fail_cnt    (fail_cnt),
        .in_cnt      (in_cnt),
        .out_cnt     (out_cnt),
        .pending     (pending)
    );

    always #5 clk = ~clk;

    // one operand on the next rising edge
    task automatic issue_operand(input logic [31:0] op, input logic sgn, input logic hr,
                                 input logic [31:0] word, input logic inx);
        @(posedge clk);
        in_valid    <= 1'b1;
        operand     <= op;
        is_signed   <= sgn;
        has_ref     <= hr;
        ref_word    <= word;
        ref_inexact <= inx;
        n_issued     = n_issued + 1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        has_ref  <= 1'b0;
    endtask

    initial begin
        logic [31:0] op;
        logic        sgn;
        int          waited;
        logic        timed_out;
        void'($urandom(32'h683feff7));
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        is_signed   = 1'b0;
        operand     = '0;
        has_ref     = 1'b0;
        ref_word    = '0;
        ref_inexact = 1'b0;
        n_issued    = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // directed rows issued back to back
        for (int i = 0; i < n_dir; i++) begin
            issue_operand(dir_rows[i].operand, dir_rows[i].is_signed, 1'b1,
                          dir_rows[i].word, dir_rows[i].inexact);
        end

        // random rows with occasional idle gaps
        // expected values come from the checker model
        for (int i = 0; i < n_rand; i++) begin
            op  = $urandom;
            op  = op >> ($urandom % 32);
            sgn = 1'($urandom % 2);
            issue_operand(op, sgn, 1'b0, 32'h0, 1'b0);
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();

        // ------------------------------------------------------------------
        // drain
        // ------------------------------------------------------------------
        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited = waited + 1;
        end
        timed_out = (pending != 0);

        $display("%0d issued, %0d results, %0d passed, %0d failed",
                 n_issued, out_cnt, pass_cnt, fail_cnt);
        if (timed_out) begin
            $display("drain timed out with %0d results still outstanding", pending);
            $display("TESTS FAILED");
        end else begin
            if (out_cnt != in_cnt) begin
                $display("accepted %0d operands but saw %0d results", in_cnt, out_cnt);
            end
            if (fail_cnt == 0 && out_cnt == in_cnt) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/fp_fmt_pkg.sv
rtl/cvt_ctrl_pkg.sv
rtl/leading_zero.sv
rtl/magnitude_prep.sv
rtl/normalize_shift.sv
rtl/round_pack.sv
rtl/cvt_ctrl.sv
rtl/int_to_float_top.sv
tb/cvt_checker.sv
tb/tb_int_to_float.sv
